/* lsu_top.f */
+incdir+design
design/lsu_pkg.sv
design/mem_bus_pkg.sv
design/lsu_issue.sv
design/load_tag_queue.sv
design/load_align.sv
design/lsu_top.sv
test/lsu_clk_gen.sv
test/lsu_chk.sv
test/lsu_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module lsu_tb -f lsu_top.f -o lsu_sim \
    && ./obj_dir/lsu_sim | tee /dev/stderr | grep -q "Simulation PASSED" \
    && echo "run.sh: pass" \
    || { echo "run.sh: fail"; exit 1; }

/* test/lsu_tb.sv */
// load/store unit testbench
`timescale 1ns/1ps

module lsu_tb;
    import lsu_pkg::*;
    import mem_bus_pkg::*;

    // rough cycle budget of all tests together
    localparam int TEST_CYCLES = 700;

    logic        clk;
    logic        rst_n;
    lsu_req_t    req;
    logic        req_valid;
    logic        ar_ready;
    logic        aw_ready;
    logic        w_ready;
    r_t          r;
    ar_t         ar;
    aw_w_t       aw_w;
    wb_t         wb;
    logic        stall;
    logic [31:0] mem [16];
    logic [31:0] shadow [16];
    logic [31:0] rd_data_q [$];
    logic [40:0] exp_q [$];
    logic [31:0] rng;
    logic [31:0] dly_rng;
    mem_op_e     loads [5] = '{LB, LH, LW, LBU, LHU};
    mem_op_e     all_ops [8] = '{LB, LH, LW, LBU, LHU, SB, SH, SW};
    int          delay;
    int          errors;
    int          mon_errors;
    int          tests_ok;
    int          tests_bad;
    int          start_errs;
    bit          resp_en;
    string       test_name;

    lsu_clk_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

    lsu_top lsu_top_i (
        .clk(clk), .rst_n(rst_n), .req_i(req), .req_valid_i(req_valid),
        .ar_ready_i(ar_ready), .aw_ready_i(aw_ready), .w_ready_i(w_ready), .r_i(r),
        .ar_o(ar), .aw_w_o(aw_w), .wb_o(wb), .mem_stall_o(stall)
    );

    function automatic logic [31:0] xorshift(logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // word contents derived from its byte address
    function automatic logic [31:0] fill(int i);
        return (32'(i) * 32'd4 * 32'h9e3779b9) ^ 32'h8c4ae019;
    endfunction

    function automatic logic [31:0] extend_lane(mem_op_e op, logic [31:0] w, logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[8*off +: 8];
        h = off[1] ? w[31:16] : w[15:0];
        case (op)
            LB:      return {{24{b[7]}}, b};
            LBU:     return {24'd0, b};
            LH:      return {{16{h[15]}}, h};
            LHU:     return {16'd0, h};
            default: return w;
        endcase
    endfunction

    task automatic check_eq(string what, logic [71:0] exp, logic [71:0] act);
        assert (exp == act) else begin
            $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    // memory model, read responses in order after a random delay
    initial begin : responder
        for (int i = 0; i < 16; i++) begin
            mem[i] = fill(i);
        end
        r = '0;
        delay = 0;
        dly_rng = 32'h7397aa16;
        forever begin
            @(posedge clk);
            // read data taken when the address is accepted
            if (ar.valid && ar_ready) begin
                rd_data_q.push_back(mem[ar.addr[5:2]]);
            end
            if (aw_w.valid && aw_ready && w_ready) begin
                for (int b = 0; b < 4; b++) begin
                    if (aw_w.strb[b]) mem[aw_w.addr[5:2]][8*b +: 8] = aw_w.data[8*b +: 8];
                end
            end
            @(negedge clk);
            r.valid = 1'b0;
            if (delay > 0) begin
                delay--;
            end else if (resp_en && rd_data_q.size() > 0) begin
                r.valid = 1'b1;
                r.data  = rd_data_q.pop_front();
                dly_rng = xorshift(dly_rng);
                delay   = int'(dly_rng % 32'd3);
            end
        end
    end

    // writebacks must come in the order the loads were issued
    always @(posedge clk) begin
        if (wb.we) begin
            assert (exp_q.size() > 0 && exp_q[0] == {wb.rd, wb.commit_id, wb.data}) else begin
                $display("CHECK FAILED %s writeback: expected %h actual %h", test_name,
                         exp_q.size() > 0 ? exp_q[0] : 41'd0, {wb.rd, wb.commit_id, wb.data});
                mon_errors++;
            end
            if (exp_q.size() > 0) void'(exp_q.pop_front());
        end
    end

    task automatic issue(mem_op_e op, logic [31:0] base, logic [31:0] off, logic [31:0] sdata,
                         logic [4:0] rd, logic [3:0] cid);
        logic [31:0] a;
        logic [31:0] d;
        logic [3:0]  s;
        a = base + off;
        d = sdata;
        s = 4'hf;
        if (op == SB) begin
            d = 32'(sdata[7:0]) << (8 * a[1:0]);
            s = 4'b0001 << a[1:0];
        end else if (op == SH) begin
            d = a[1] ? {sdata[15:0], 16'd0} : {16'd0, sdata[15:0]};
            s = a[1] ? 4'b1100 : 4'b0011;
        end
        @(negedge clk);
        req = '{op: op, base: base, offset: off, store_data: sdata, rd: rd, commit_id: cid};
        req_valid = 1'b1;
        #1;
        while (stall) begin
            @(negedge clk);
            #1;
        end
        if (op inside {SB, SH, SW}) begin
            check_eq("store", 72'({1'b1, a, d, s}),
                     72'({aw_w.valid, aw_w.addr, aw_w.data, aw_w.strb}));
            for (int b = 0; b < 4; b++) begin
                if (s[b]) shadow[a[5:2]][8*b +: 8] = d[8*b +: 8];
            end
        end else begin
            check_eq("load address", 72'({1'b1, a}), 72'({ar.valid, ar.addr}));
            exp_q.push_back({rd, cid, extend_lane(op, shadow[a[5:2]], a[1:0])});
        end
        @(posedge clk);
    endtask

    task automatic idle_and_drain();
        @(negedge clk);
        req_valid = 1'b0;
        while (exp_q.size() > 0) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic finish_test();
        if (errors + mon_errors == start_errs) tests_ok++;
        else tests_bad++;
        $display("%s: %s", test_name, (errors + mon_errors == start_errs) ? "ok" : "FAILED");
        start_errs = errors + mon_errors;
    endtask

    task automatic test_reset();
        test_name = "reset";
        wait (rst_n);
        @(negedge clk);
        #1;
        check_eq("idle outputs", 72'(0), 72'({wb.we, ar.valid, aw_w.valid, stall}));
        finish_test();
    endtask

    task automatic test_stores();
        test_name = "store_lanes";
        for (int o = 0; o < 4; o++) issue(SB, 32'h1020, 32'(o), 32'h5a5a_a5c3 + 32'(o), 0, 0);
        for (int o = 0; o < 4; o += 2) issue(SH, 32'h1030, 32'(o), 32'h1234_9abc, 0, 0);
        issue(SW, 32'h1000, 32'h34, 32'hdead_beef, 0, 0);
        idle_and_drain();
        finish_test();
    endtask

    task automatic test_loads();
        int k;
        test_name = "load_extension";
        k = 0;
        foreach (loads[i]) begin
            for (int o = 0; o < 4; o++) begin
                if (loads[i] == LW && o != 0) continue;
                if (loads[i] inside {LH, LHU} && o[0]) continue;
                issue(loads[i], 32'h1020, 32'(o), 0, 5'(k + 1), 4'(k));
                k++;
            end
        end
        idle_and_drain();
        finish_test();
    endtask

    task automatic test_order();
        test_name = "load_order";
        for (int i = 0; i < 4; i++) issue(LW, 32'h1000, 32'(4 * i), 0, 5'(20 + i), 4'(9 + i));
        idle_and_drain();
        finish_test();
    endtask

    task automatic test_backpressure();
        test_name = "backpressure";
        ar_ready = 1'b0;
        @(negedge clk);
        req = '{op: LW, base: 32'h1000, offset: 0, store_data: 0, rd: 7, commit_id: 1};
        req_valid = 1'b1;
        repeat (4) @(negedge clk);
        check_eq("stall without ar_ready", 72'(1), 72'(stall));
        check_eq("read address held", 72'({1'b1, 32'h1000}), 72'({ar.valid, ar.addr}));
        req_valid = 1'b0;
        ar_ready = 1'b1;
        resp_en = 1'b0;
        for (int i = 0; i < 4; i++) issue(LBU, 32'h1004, 32'(i), 0, 5'(i + 1), 4'(i));
        @(negedge clk);
        req.rd = 5'd5;
        repeat (3) @(negedge clk);
        #1;
        check_eq("stall on full queue", 72'(1), 72'(stall));
        resp_en = 1'b1;
        issue(LHU, 32'h1008, 32'h2, 0, 5, 4);
        idle_and_drain();
        aw_ready = 1'b1;
        w_ready = 1'b0;
        req = '{op: SW, base: 32'h1000, offset: 0, store_data: 1, rd: 0, commit_id: 0};
        req_valid = 1'b1;
        #1;
        check_eq("stall without w_ready", 72'(1), 72'(stall));
        aw_ready = 1'b0;
        w_ready = 1'b1;
        #1;
        check_eq("stall without aw_ready", 72'(1), 72'(stall));
        req_valid = 1'b0;
        aw_ready = 1'b1;
        finish_test();
    endtask

    task automatic test_random();
        mem_op_e     op;
        logic [31:0] off;
        test_name = "random_mix";
        for (int n = 0; n < 40; n++) begin
            rng = xorshift(rng);
            op = all_ops[rng[2:0]];
            off = {30'd0, rng[4:3]};
            if (op inside {LH, LHU, SH}) off[0] = 1'b0;
            if (op inside {LW, SW}) off = 0;
            issue(op, {26'd1, rng[9:6], 2'b00}, off, xorshift(rng), rng[14:10], rng[18:15]);
        end
        idle_and_drain();
        finish_test();
    endtask

    // watchdog
    initial begin
        #(TEST_CYCLES * 40 + 4000);
        $display("timeout: the tests did not finish in the expected time");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        req = '0;
        req.op = NONE;
        req_valid = 1'b0;
        ar_ready = 1'b1;
        aw_ready = 1'b1;
        w_ready = 1'b1;
        resp_en = 1'b1;
        rng = 32'h7397aa16;
        for (int i = 0; i < 16; i++) shadow[i] = fill(i);
        test_reset();
        test_stores();
        test_loads();
        test_order();
        test_backpressure();
        test_random();
        $display("tests passed %0d failed %0d", tests_ok, tests_bad);
        if (errors + mon_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end
endmodule

/* test/lsu_chk.sv */
// load tag queue assertions
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_chk (
    input logic                                  clk,
    input logic                                  rst_n,
    input logic                                  push_i,
    input logic                                  pop_i,
    input logic                                  full_o,
    input logic                                  head_valid_o,
    input logic [$clog2(`LSU_LQ_DEPTH + 1)-1:0]  count
);
    localparam int CNT_W = $clog2(`LSU_LQ_DEPTH + 1);

    // occupancy rebuilt from the raw push and pop requests
    logic [CNT_W-1:0] model_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            model_cnt <= '0;
        end else begin
            model_cnt <= model_cnt + CNT_W'(push_i) - CNT_W'(pop_i);
        end
    end

    // issue must hold a load back while the queue is full
    push_while_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(push_i && (model_cnt == CNT_W'(`LSU_LQ_DEPTH))))
        else $error("tag pushed into a full queue");

    pop_while_empty: assert property (@(posedge clk) disable iff (!rst_n)
        !(pop_i && (model_cnt == '0)))
        else $error("tag popped from an empty queue");

    head_valid_count: assert property (@(posedge clk) disable iff (!rst_n)
        (count == model_cnt) && (head_valid_o == (model_cnt != '0)) &&
        (full_o == (model_cnt == CNT_W'(`LSU_LQ_DEPTH))))
        else $error("queue occupancy disagrees with pushes and pops");
endmodule

bind load_tag_queue lsu_chk u_chk (.*);

/* test/lsu_clk_gen.sv */
// testbench clock and reset
`timescale 1ns/1ps

module lsu_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);
    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    // reset held low for three cycles
    initial begin
        rst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end
endmodule

/* design/lsu_top.sv */
// load/store unit top level
`timescale 1ns/1ps

module lsu_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  lsu_pkg::lsu_req_t    req_i,
    input  logic                 req_valid_i,
    input  logic                 ar_ready_i,
    input  logic                 aw_ready_i,
    input  logic                 w_ready_i,
    input  mem_bus_pkg::r_t      r_i,
    output mem_bus_pkg::ar_t     ar_o,
    output mem_bus_pkg::aw_w_t   aw_w_o,
    output lsu_pkg::wb_t         wb_o,
    output logic                 mem_stall_o
);
    import lsu_pkg::*;

    // issue to queue
    logic       lq_push;
    load_tag_t  lq_tag;
    logic       lq_full;

    // queue to aligner
    load_tag_t  lq_head;
    logic       lq_head_valid;
    logic       lq_pop;

    lsu_issue u_issue (
        .req_i       (req_i),
        .req_valid_i (req_valid_i),
        .ar_ready_i  (ar_ready_i),
        .aw_ready_i  (aw_ready_i),
        .w_ready_i   (w_ready_i),
        .lq_full_i   (lq_full),
        .ar_o        (ar_o),
        .aw_w_o      (aw_w_o),
        .push_o      (lq_push),
        .tag_o       (lq_tag),
        .mem_stall_o (mem_stall_o)
    );

    load_tag_queue u_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .push_i       (lq_push),
        .tag_i        (lq_tag),
        .pop_i        (lq_pop),
        .full_o       (lq_full),
        .head_o       (lq_head),
        .head_valid_o (lq_head_valid)
    );

    load_align u_align (
        .r_i          (r_i),
        .head_i       (lq_head),
        .head_valid_i (lq_head_valid),
        .pop_o        (lq_pop),
        .wb_o         (wb_o)
    );

endmodule

/* design/load_align.sv */
// load data alignment and writeback
`timescale 1ns/1ps
`include "lsu_config.svh"

module load_align (
    input  mem_bus_pkg::r_t     r_i,
    input  lsu_pkg::load_tag_t  head_i,
    input  logic                head_valid_i,
    output logic                pop_o,
    output lsu_pkg::wb_t        wb_o
);
    import lsu_pkg::*;

    logic                  fire;
    logic [7:0]            byte_sel;
    logic [15:0]           half_sel;
    logic [`LSU_XLEN-1:0]  ld_data;

    // data without a waiting tag is dropped
    assign fire  = r_i.valid && head_valid_i;
    assign pop_o = fire;

    // lane picked by the low address bits
    assign byte_sel = r_i.data[{head_i.byte_off, 3'b000} +: 8];
    assign half_sel = r_i.data[{head_i.byte_off[1], 4'b0000} +: 16];

    always_comb begin
        case (head_i.op)
            LB:      ld_data = {{(`LSU_XLEN - 8){byte_sel[7]}}, byte_sel};
            LBU:     ld_data = {{(`LSU_XLEN - 8){1'b0}}, byte_sel};
            LH:      ld_data = {{(`LSU_XLEN - 16){half_sel[15]}}, half_sel};
            LHU:     ld_data = {{(`LSU_XLEN - 16){1'b0}}, half_sel};
            LW:      ld_data = r_i.data;
            default: ld_data = '0;
        endcase
    end

    assign wb_o.we        = fire;
    assign wb_o.rd        = head_i.rd;
    assign wb_o.data      = ld_data;
    assign wb_o.commit_id = head_i.commit_id;

endmodule

/* design/load_tag_queue.sv */
// pending load tag queue
`timescale 1ns/1ps
`include "lsu_config.svh"

module load_tag_queue (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                push_i,
    input  lsu_pkg::load_tag_t  tag_i,
    input  logic                pop_i,
    output logic                full_o,
    output lsu_pkg::load_tag_t  head_o,
    output logic                head_valid_o
);
    import lsu_pkg::*;

    localparam int DEPTH = `LSU_LQ_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    load_tag_t          tags [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               do_push;
    logic               do_pop;

    assign full_o       = (count == CNT_W'(DEPTH));
    assign head_valid_o = (count != '0);
    assign head_o       = tags[rd_ptr];

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && head_valid_o;

    // tag storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            tags[wr_ptr] <= tag_i;
        end
    end

    // pointers wrap at the last slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* design/lsu_issue.sv */
// load/store request issue
`timescale 1ns/1ps
`include "lsu_config.svh"

module lsu_issue (
    input  lsu_pkg::lsu_req_t     req_i,
    input  logic                  req_valid_i,
    input  logic                  ar_ready_i,
    input  logic                  aw_ready_i,
    input  logic                  w_ready_i,
    input  logic                  lq_full_i,
    output mem_bus_pkg::ar_t      ar_o,
    output mem_bus_pkg::aw_w_t    aw_w_o,
    output logic                  push_o,
    output lsu_pkg::load_tag_t    tag_o,
    output logic                  mem_stall_o
);
    import lsu_pkg::*;

    logic [`LSU_XLEN-1:0]   addr;
    logic [1:0]             byte_off;
    logic                   is_load;
    logic                   is_store;
    logic [`LSU_XLEN-1:0]   st_data;
    logic [`LSU_XLEN/8-1:0] st_strb;

    assign addr     = req_i.base + req_i.offset;
    assign byte_off = addr[1:0];

    // classify the request
    assign is_load  = req_valid_i && (req_i.op inside {LB, LH, LW, LBU, LHU});
    assign is_store = req_valid_i && (req_i.op inside {SB, SH, SW});

    // move store data into the addressed lane
    always_comb begin
        st_data = '0;
        st_strb = '0;
        case (req_i.op)
            SB: begin
                st_data = `LSU_XLEN'(req_i.store_data[7:0]) << {byte_off, 3'b000};
                st_strb = 4'b0001 << byte_off;
            end
            SH: begin
                st_data = `LSU_XLEN'(req_i.store_data[15:0]) << {byte_off[1], 4'b0000};
                st_strb = byte_off[1] ? 4'b1100 : 4'b0011;
            end
            SW: begin
                st_data = req_i.store_data;
                st_strb = 4'b1111;
            end
            default: begin
                st_data = '0;
                st_strb = '0;
            end
        endcase
    end

    // read address, held back while the tag queue has no room
    assign ar_o.valid = is_load && !lq_full_i;
    assign ar_o.addr  = addr;

    // address and data go out as one transfer
    assign aw_w_o.valid = is_store;
    assign aw_w_o.addr  = addr;
    assign aw_w_o.data  = st_data;
    assign aw_w_o.strb  = st_strb;

    // a tag enters the queue in the load's address handshake cycle
    assign push_o            = ar_o.valid && ar_ready_i;
    assign tag_o.op          = req_i.op;
    assign tag_o.byte_off    = byte_off;
    assign tag_o.rd          = req_i.rd;
    assign tag_o.commit_id   = req_i.commit_id;

    // core holds the request while this is high
    assign mem_stall_o = (is_load && (lq_full_i || !ar_ready_i)) ||
                         (is_store && (!aw_ready_i || !w_ready_i));

endmodule

/* design/mem_bus_pkg.sv */
// memory bus channel types
`include "lsu_config.svh"

package mem_bus_pkg;

    // one strobe bit per data byte
    localparam int STRB_W = `LSU_XLEN / 8;

    // read address channel
    typedef struct packed {
        logic                  valid;
        logic [`LSU_XLEN-1:0]  addr;
    } ar_t;

    // write address and data, taken together
    typedef struct packed {
        logic                  valid;
        logic [`LSU_XLEN-1:0]  addr;
        logic [`LSU_XLEN-1:0]  data;
        logic [STRB_W-1:0]     strb;
    } aw_w_t;

    // read data channel, always accepted
    typedef struct packed {
        logic                  valid;
        logic [`LSU_XLEN-1:0]  data;
    } r_t;

endpackage

/* design/lsu_pkg.sv */
// core side load/store types
`include "lsu_config.svh"

package lsu_pkg;

    // memory opcodes, NONE for an idle slot
    typedef enum logic [3:0] {
        NONE = 4'd0,
        LB   = 4'd1,
        LH   = 4'd2,
        LW   = 4'd3,
        LBU  = 4'd4,
        LHU  = 4'd5,
        SB   = 4'd6,
        SH   = 4'd7,
        SW   = 4'd8
    } mem_op_e;

    // one memory instruction from the core
    typedef struct packed {
        mem_op_e                 op;
        logic [`LSU_XLEN-1:0]    base;
        logic [`LSU_XLEN-1:0]    offset;
        logic [`LSU_XLEN-1:0]    store_data;
        logic [`LSU_REG_AW-1:0]  rd;
        logic [`LSU_CID_W-1:0]   commit_id;
    } lsu_req_t;

    // context kept for a load until its data returns
    typedef struct packed {
        mem_op_e                 op;
        logic [1:0]              byte_off;
        logic [`LSU_REG_AW-1:0]  rd;
        logic [`LSU_CID_W-1:0]   commit_id;
    } load_tag_t;

    // register writeback
    typedef struct packed {
        logic                    we;
        logic [`LSU_REG_AW-1:0]  rd;
        logic [`LSU_XLEN-1:0]    data;
        logic [`LSU_CID_W-1:0]   commit_id;
    } wb_t;

endpackage

/* design/lsu_config.svh */
// load/store unit parameters
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// data and address width
`define LSU_XLEN 32

// register file address width
`define LSU_REG_AW 5

// commit id width
`define LSU_CID_W 4

// loads that may wait for data at once
`define LSU_LQ_DEPTH 4

`endif
